//--- Bender.yml
package:
  name: noncomp_opgroup

sources:
  # Packages first, the modules refer to them by scoped name
  - src/fp_fmt_pkg.sv
  - src/fp_op_pkg.sv
  - src/noncomp_core.sv
  - src/noncomp_fmt_slice.sv
  - src/rr_output_arbiter.sv
  - src/noncomp_opgroup_block.sv

  - target: simulation
    include_dirs:
      - include
    files:
      - testbench/tb_noncomp_opgroup_block.sv

//--- src.f
+incdir+include
src/fp_fmt_pkg.sv
src/fp_op_pkg.sv
src/noncomp_core.sv
src/noncomp_fmt_slice.sv
src/rr_output_arbiter.sv
src/noncomp_opgroup_block.sv
testbench/tb_noncomp_opgroup_block.sv

//--- src/fp_fmt_pkg.sv
// --------------------------------------------------
// Number formats for the non-computational FP group
// Bit layouts, NaN-boxed operand view, status flags
// --------------------------------------------------
`default_nettype none

package fp_fmt_pkg;

  // --------------------------------------------------
  // Formats
  // --------------------------------------------------
  typedef enum logic [0:0] {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_format_e;

  localparam int unsigned NumFormats = 2;

  // Operands and results always travel in one word
  localparam int unsigned WordWidth = 32;

  localparam int unsigned Fp32ExpBits = 8;
  localparam int unsigned Fp32ManBits = 23;
  localparam int unsigned Fp16ExpBits = 5;
  localparam int unsigned Fp16ManBits = 10;

  // --------------------------------------------------
  // Bit layouts
  // --------------------------------------------------
  typedef struct packed {
    logic                   sign;
    logic [Fp32ExpBits-1:0] exponent;
    logic [Fp32ManBits-1:0] mantissa;
  } fp32_t;

  typedef struct packed {
    logic                   sign;
    logic [Fp16ExpBits-1:0] exponent;
    logic [Fp16ManBits-1:0] mantissa;
  } fp16_t;

  // Narrow value in the low half, all ones above when properly boxed
  typedef struct packed {
    logic [15:0] box;
    fp16_t       value;
  } boxed16_t;

  // One operand word, read as FP32 or as a boxed FP16
  typedef union packed {
    fp32_t    fp32;
    boxed16_t fp16;
  } operand_word_u;

  // --------------------------------------------------
  // Exception flags
  // --------------------------------------------------
  typedef struct packed {
    logic nv;  // invalid operation
    logic dz;  // divide by zero
    logic of;  // overflow
    logic uf;  // underflow
    logic nx;  // inexact
  } status_t;

  // Canonical quiet NaNs
  localparam logic [WordWidth-1:0] CanonNan32 = 32'h7FC0_0000;
  localparam logic [WordWidth-1:0] CanonNan16 = 32'hFFFF_7E00;

endpackage

`default_nettype wire

//--- src/fp_op_pkg.sv
// --------------------------------------------------
// Operations handled by the non-computational group
// Request and response words used at the block ports
// --------------------------------------------------
`default_nettype none

package fp_op_pkg;

  // --------------------------------------------------
  // Operation codes
  // --------------------------------------------------
  typedef enum logic [2:0] {
    MIN   = 3'd0,
    MAX   = 3'd1,
    SGNJ  = 3'd2,
    SGNJN = 3'd3,
    SGNJX = 3'd4,
    FEQ   = 3'd5,
    FLT   = 3'd6,
    FLE   = 3'd7
  } operation_e;

  // Caller-side identifier, returned with the result
  typedef logic [3:0] tag_t;

  // --------------------------------------------------
  // Request
  // --------------------------------------------------
  typedef struct packed {
    fp_fmt_pkg::operand_word_u operand_a;
    fp_fmt_pkg::operand_word_u operand_b;
    operation_e                op;
    // Selects the slice, never seen inside it
    fp_fmt_pkg::fp_format_e    dst_fmt;
    tag_t                      tag;
  } req_t;

  // --------------------------------------------------
  // Response
  // --------------------------------------------------
  typedef struct packed {
    logic [fp_fmt_pkg::WordWidth-1:0] result;
    fp_fmt_pkg::status_t              status;
    tag_t                             tag;
  } resp_t;

endpackage

`default_nettype wire

//--- src/noncomp_core.sv
// --------------------------------------------------
// Min/max, sign injection and compares for one format
// Purely combinational, instantiated inside a slice
// --------------------------------------------------
`default_nettype none

module noncomp_core #(
  parameter fp_fmt_pkg::fp_format_e Fmt = fp_fmt_pkg::FP32
) (
  input  fp_fmt_pkg::operand_word_u         operand_a_i,
  input  fp_fmt_pkg::operand_word_u         operand_b_i,
  input  fp_op_pkg::operation_e             op_i,
  output logic [fp_fmt_pkg::WordWidth-1:0]  result_o,
  output fp_fmt_pkg::status_t               status_o
);

  localparam bit IsFp32 = (Fmt == fp_fmt_pkg::FP32);
  localparam int unsigned ExpBits = IsFp32 ? fp_fmt_pkg::Fp32ExpBits : fp_fmt_pkg::Fp16ExpBits;
  localparam int unsigned ManBits = IsFp32 ? fp_fmt_pkg::Fp32ManBits : fp_fmt_pkg::Fp16ManBits;
  localparam int unsigned Width = 1 + ExpBits + ManBits;
  localparam logic [Width-1:0] CanonNan = IsFp32 ? fp_fmt_pkg::CanonNan32[Width-1:0]
                                                 : fp_fmt_pkg::CanonNan16[Width-1:0];

  logic [Width-1:0]   a_val, b_val;
  logic               a_sign, b_sign;
  logic [ExpBits-1:0] a_exp, b_exp;
  logic [ManBits-1:0] a_man, b_man;
  logic [Width-2:0]   a_mag, b_mag;
  logic               a_nan, b_nan, a_snan, b_snan, a_zero, b_zero;
  logic               any_nan, any_snan, both_zero;
  logic               a_below_b, equal, less;
  logic [Width-1:0]   res_val;
  logic               cmp_bit, is_cmp;
  logic [fp_fmt_pkg::WordWidth-1:0] cmp_word;

  // --------------------------------------------------
  // Operand views
  // --------------------------------------------------
  if (IsFp32) begin : gen_fp32_view
    assign a_val = operand_a_i.fp32;
    assign b_val = operand_b_i.fp32;
  end else begin : gen_fp16_view
    // Unboxed values read as canonical NaN
    assign a_val = (&operand_a_i.fp16.box) ? operand_a_i.fp16.value : CanonNan;
    assign b_val = (&operand_b_i.fp16.box) ? operand_b_i.fp16.value : CanonNan;
  end

  assign {a_sign, a_exp, a_man} = a_val;
  assign {b_sign, b_exp, b_man} = b_val;
  assign a_mag = {a_exp, a_man};
  assign b_mag = {b_exp, b_man};

  // Classification
  assign a_nan  = (&a_exp) & (|a_man);
  assign b_nan  = (&b_exp) & (|b_man);
  assign a_snan = a_nan & ~a_man[ManBits-1];
  assign b_snan = b_nan & ~b_man[ManBits-1];
  assign a_zero = ~|a_mag;
  assign b_zero = ~|b_mag;

  assign any_nan   = a_nan | b_nan;
  assign any_snan  = a_snan | b_snan;
  assign both_zero = a_zero & b_zero;

  // Total order on sign-magnitude, -0 sits below +0
  always_comb begin
    if (a_sign != b_sign) begin
      a_below_b = a_sign;
    end else if (a_sign) begin
      a_below_b = (a_mag > b_mag);
    end else begin
      a_below_b = (a_mag < b_mag);
    end
  end

  // Compares treat both zeros as equal
  assign equal = (a_val == b_val) | both_zero;
  assign less  = a_below_b & ~both_zero;

  // --------------------------------------------------
  // Operation select
  // --------------------------------------------------
  always_comb begin
    res_val  = a_val;
    cmp_bit  = 1'b0;
    is_cmp   = 1'b0;
    status_o = '0;
    unique case (op_i)
      fp_op_pkg::MIN, fp_op_pkg::MAX: begin
        if (a_nan && b_nan) begin
          res_val = CanonNan;
        end else if (a_nan) begin
          res_val = b_val;
        end else if (b_nan) begin
          res_val = a_val;
        end else if ((op_i == fp_op_pkg::MIN) == a_below_b) begin
          res_val = a_val;
        end else begin
          res_val = b_val;
        end
        status_o.nv = any_snan;
      end
      fp_op_pkg::SGNJ:  res_val = {b_sign, a_mag};
      fp_op_pkg::SGNJN: res_val = {~b_sign, a_mag};
      fp_op_pkg::SGNJX: res_val = {a_sign ^ b_sign, a_mag};
      fp_op_pkg::FEQ: begin
        is_cmp      = 1'b1;
        cmp_bit     = ~any_nan & equal;
        status_o.nv = any_snan;
      end
      fp_op_pkg::FLT: begin
        is_cmp      = 1'b1;
        cmp_bit     = ~any_nan & less;
        status_o.nv = any_nan;
      end
      fp_op_pkg::FLE: begin
        is_cmp      = 1'b1;
        cmp_bit     = ~any_nan & (less | equal);
        status_o.nv = any_nan;
      end
      default: ;
    endcase
  end

  assign cmp_word = {{(fp_fmt_pkg::WordWidth-1){1'b0}}, cmp_bit};

  // Narrow results go out NaN-boxed
  if (IsFp32) begin : gen_fp32_result
    assign result_o = is_cmp ? cmp_word : res_val;
  end else begin : gen_fp16_result
    assign result_o = is_cmp ? cmp_word : {{(fp_fmt_pkg::WordWidth-Width){1'b1}}, res_val};
  end

endmodule

`default_nettype wire

//--- src/noncomp_fmt_slice.sv
// --------------------------------------------------
// One format slice, core followed by an elastic pipe
// Depth set by NumPipeRegs, zero gives a bypass
// --------------------------------------------------
`default_nettype none

module noncomp_fmt_slice #(
  parameter fp_fmt_pkg::fp_format_e Fmt         = fp_fmt_pkg::FP32,
  parameter int unsigned            NumPipeRegs = 0
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  fp_op_pkg::req_t   req_i,
  input  logic              in_valid_i,
  output logic              in_ready_o,
  input  logic              flush_i,
  output fp_op_pkg::resp_t  resp_o,
  output logic              out_valid_o,
  input  logic              out_ready_i,
  output logic              busy_o
);

  logic [fp_fmt_pkg::WordWidth-1:0] core_result;
  fp_fmt_pkg::status_t              core_status;
  fp_op_pkg::resp_t                 core_resp;

  // Stage 0 is the slice input, stage NumPipeRegs the output
  fp_op_pkg::resp_t [NumPipeRegs:0] stage_data;
  logic [NumPipeRegs:0]             stage_valid;
  logic [NumPipeRegs:0]             stage_ready;

  noncomp_core #(
    .Fmt ( Fmt )
  ) i_core (
    .operand_a_i ( req_i.operand_a ),
    .operand_b_i ( req_i.operand_b ),
    .op_i        ( req_i.op        ),
    .result_o    ( core_result     ),
    .status_o    ( core_status     )
  );

  assign core_resp = '{result: core_result, status: core_status, tag: req_i.tag};

  assign stage_data[0]  = core_resp;
  assign stage_valid[0] = in_valid_i;
  assign in_ready_o     = stage_ready[0];

  // --------------------------------------------------
  // Pipeline registers
  // --------------------------------------------------
  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_pipe
    // Advance into an empty stage or one that moves on
    assign stage_ready[i] = stage_ready[i+1] | ~stage_valid[i+1];

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        stage_valid[i+1] <= 1'b0;
      end else if (flush_i) begin
        stage_valid[i+1] <= 1'b0;
      end else if (stage_ready[i]) begin
        stage_valid[i+1] <= stage_valid[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (stage_valid[i] && stage_ready[i]) begin
        stage_data[i+1] <= stage_data[i];
      end
    end
  end

  assign stage_ready[NumPipeRegs] = out_ready_i;
  assign out_valid_o              = stage_valid[NumPipeRegs];
  assign resp_o                   = stage_data[NumPipeRegs];

  // Registered stages only, the input does not count
  assign busy_o = |(stage_valid >> 1);

  // Stalled output must hold, only meaningful with registers
  if (NumPipeRegs > 0) begin : gen_hold_check
    assert property (@(posedge clk_i) disable iff (rst_i)
      out_valid_o && !out_ready_i && !flush_i |=> out_valid_o && $stable(resp_o));
  end

endmodule

`default_nettype wire

//--- src/noncomp_opgroup_block.sv
// --------------------------------------------------
// Non-computational FP group with one slice per format
// Valid/ready handshake on both sides with flush and busy
// --------------------------------------------------
`default_nettype none

module noncomp_opgroup_block #(
  parameter int unsigned Fp32PipeRegs = 2,
  parameter int unsigned Fp16PipeRegs = 1
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  fp_op_pkg::req_t   req_i,
  input  logic              in_valid_i,
  output logic              in_ready_o,
  input  logic              flush_i,
  output fp_op_pkg::resp_t  resp_o,
  output logic              out_valid_o,
  input  logic              out_ready_i,
  output logic              busy_o
);

  logic [fp_fmt_pkg::NumFormats-1:0] fmt_in_ready;
  logic [fp_fmt_pkg::NumFormats-1:0] fmt_out_valid;
  logic [fp_fmt_pkg::NumFormats-1:0] fmt_out_ready;
  logic [fp_fmt_pkg::NumFormats-1:0] fmt_busy;
  fp_op_pkg::resp_t [fp_fmt_pkg::NumFormats-1:0] fmt_resp;

  // --------------------------------------------------
  // Input steering
  // --------------------------------------------------
  // Ready comes from the slice picked by dst_fmt
  assign in_ready_o = in_valid_i & fmt_in_ready[req_i.dst_fmt];

  for (genvar fmt = 0; fmt < fp_fmt_pkg::NumFormats; fmt++) begin : gen_slices
    localparam fp_fmt_pkg::fp_format_e SliceFmt = fp_fmt_pkg::fp_format_e'(fmt);
    localparam int unsigned SliceDepth =
        (SliceFmt == fp_fmt_pkg::FP32) ? Fp32PipeRegs : Fp16PipeRegs;

    logic slice_valid;

    assign slice_valid = in_valid_i & (req_i.dst_fmt == SliceFmt);

    noncomp_fmt_slice #(
      .Fmt         ( SliceFmt   ),
      .NumPipeRegs ( SliceDepth )
    ) i_slice (
      .clk_i,
      .rst_i,
      .req_i,
      .in_valid_i  ( slice_valid        ),
      .in_ready_o  ( fmt_in_ready[fmt]  ),
      .flush_i,
      .resp_o      ( fmt_resp[fmt]      ),
      .out_valid_o ( fmt_out_valid[fmt] ),
      .out_ready_i ( fmt_out_ready[fmt] ),
      .busy_o      ( fmt_busy[fmt]      )
    );
  end

  // --------------------------------------------------
  // Output merge
  // --------------------------------------------------
  rr_output_arbiter #(
    .NumIn ( fp_fmt_pkg::NumFormats )
  ) i_arbiter (
    .clk_i,
    .rst_i,
    .flush_i,
    .valid_i ( fmt_out_valid ),
    .ready_o ( fmt_out_ready ),
    .data_i  ( fmt_resp      ),
    .valid_o ( out_valid_o   ),
    .ready_i ( out_ready_i   ),
    .data_o  ( resp_o        )
  );

  assign busy_o = |fmt_busy;

  // All in-flight work is gone one cycle after a flush
  assert property (@(posedge clk_i) disable iff (rst_i) flush_i |=> !busy_o);

endmodule

`default_nettype wire

//--- src/rr_output_arbiter.sv
// --------------------------------------------------
// Round-robin merge of slice results onto one port
// Choice is held while the output is stalled
// --------------------------------------------------
`default_nettype none

module rr_output_arbiter #(
  parameter int unsigned NumIn = 2
) (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          flush_i,
  input  logic [NumIn-1:0]              valid_i,
  output logic [NumIn-1:0]              ready_o,
  input  fp_op_pkg::resp_t [NumIn-1:0]  data_i,
  output logic                          valid_o,
  input  logic                          ready_i,
  output fp_op_pkg::resp_t              data_o
);

  localparam int unsigned IdxWidth = (NumIn > 1) ? $clog2(NumIn) : 1;

  logic [IdxWidth-1:0] rr_q;
  logic [IdxWidth-1:0] lock_idx_q;
  logic                lock_q;
  logic [IdxWidth-1:0] next_idx;
  logic [IdxWidth-1:0] sel_idx;

  // First valid input at or after the pointer
  always_comb begin : find_next
    int unsigned cand;
    next_idx = rr_q;
    for (int k = int'(NumIn) - 1; k >= 0; k--) begin
      cand = (int'(rr_q) + k) % NumIn;
      if (valid_i[cand]) begin
        next_idx = IdxWidth'(cand);
      end
    end
  end

  assign sel_idx = lock_q ? lock_idx_q : next_idx;
  assign valid_o = valid_i[sel_idx];
  assign data_o  = data_i[sel_idx];

  always_comb begin
    ready_o          = '0;
    ready_o[sel_idx] = ready_i & valid_o;
  end

  // --------------------------------------------------
  // Pointer and lock
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rr_q   <= '0;
      lock_q <= 1'b0;
    end else begin
      // Move past the winner only on a real transfer
      if (valid_o && ready_i) begin
        rr_q <= (sel_idx == IdxWidth'(NumIn - 1)) ? '0 : sel_idx + 1'b1;
      end
      lock_q <= valid_o & ~ready_i & ~flush_i;
    end
  end

  always_ff @(posedge clk_i) begin
    lock_idx_q <= sel_idx;
  end

  // Never idle while an input waits and no choice is held
  assert property (@(posedge clk_i) disable iff (rst_i) !lock_q && (|valid_i) |-> valid_o);

endmodule

`default_nettype wire

//--- include/tb_ref_model.svh
// --------------------------------------------------
// Reference model and typed checks for the opgroup
// Included inside the testbench top module
// --------------------------------------------------
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Fibonacci LFSR, taps 32 22 2 1, one step per bit
function automatic logic [31:0] take_bits(input int n);
  logic [31:0] bits;
  logic        fb;
  bits = '0;
  for (int i = 0; i < n; i++) begin
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    bits = {bits[30:0], fb};
  end
  return bits;
endfunction

// Expected response, values ordered through a signed key
function automatic fp_op_pkg::resp_t ref_result(input fp_op_pkg::req_t req);
  int               width;
  int               man_bits;
  logic [31:0]      wa, wb, mag_mask, man_mask, canon, val, ma, mb;
  logic             sa, sb;
  bit               na, nb, sna, snb, a_first, is_cmp;
  longint           ka, kb;
  fp_op_pkg::resp_t r;
  wa = req.operand_a;
  wb = req.operand_b;
  width = (req.dst_fmt == fp_fmt_pkg::FP32) ? 32 : 16;
  man_bits = (req.dst_fmt == fp_fmt_pkg::FP32) ? 23 : 10;
  canon = (req.dst_fmt == fp_fmt_pkg::FP32) ? 32'h7fc0_0000 : 32'h0000_7e00;
  if (req.dst_fmt == fp_fmt_pkg::FP16) begin
    // Narrow operands without a full box read as canonical NaN
    wa = (wa[31:16] == 16'hffff) ? (wa & 32'h0000_ffff) : canon;
    wb = (wb[31:16] == 16'hffff) ? (wb & 32'h0000_ffff) : canon;
  end
  mag_mask = (32'd1 << (width - 1)) - 1;
  man_mask = (32'd1 << man_bits) - 1;
  sa = wa[width-1];
  sb = wb[width-1];
  ma = wa & mag_mask;
  mb = wb & mag_mask;
  na = ((ma >> man_bits) == (mag_mask >> man_bits)) && ((ma & man_mask) != 0);
  nb = ((mb >> man_bits) == (mag_mask >> man_bits)) && ((mb & man_mask) != 0);
  sna = na && !ma[man_bits-1];
  snb = nb && !mb[man_bits-1];
  ka = sa ? -longint'(ma) : longint'(ma);
  kb = sb ? -longint'(mb) : longint'(mb);
  // Equal keys with a negative a means -0 against +0
  a_first = (ka < kb) || ((ka == kb) && sa);
  r = '0;
  r.tag = req.tag;
  is_cmp = 1'b0;
  val = wa;
  case (req.op)
    fp_op_pkg::MIN, fp_op_pkg::MAX: begin
      if (na && nb) val = canon;
      else if (na) val = wb;
      else if (nb) val = wa;
      else if (req.op == fp_op_pkg::MIN) val = a_first ? wa : wb;
      else val = a_first ? wb : wa;
      r.status.nv = sna || snb;
    end
    fp_op_pkg::SGNJ:  val = ma | ({31'b0, sb} << (width - 1));
    fp_op_pkg::SGNJN: val = ma | ({31'b0, ~sb} << (width - 1));
    fp_op_pkg::SGNJX: val = ma | ({31'b0, sa ^ sb} << (width - 1));
    fp_op_pkg::FEQ: begin
      is_cmp = 1'b1;
      r.result = {31'b0, !na && !nb && (ka == kb)};
      r.status.nv = sna || snb;
    end
    default: begin
      is_cmp = 1'b1;
      if (req.op == fp_op_pkg::FLT) r.result = {31'b0, !na && !nb && (ka < kb)};
      else r.result = {31'b0, !na && !nb && (ka <= kb)};
      r.status.nv = na || nb;
    end
  endcase
  if (!is_cmp) begin
    r.result = (width == 16) ? {16'hffff, val[15:0]} : val;
  end
  return r;
endfunction

task automatic check_result(input string name, input logic [fp_fmt_pkg::WordWidth-1:0] exp_v,
                            input logic [fp_fmt_pkg::WordWidth-1:0] act_v);
  if (act_v !== exp_v) begin
    fail_run($sformatf("MISMATCH %s result: expected %h, actual %h", name, exp_v, act_v));
  end
endtask

task automatic check_status(input string name, input fp_fmt_pkg::status_t exp_v,
                            input fp_fmt_pkg::status_t act_v);
  if (act_v !== exp_v) begin
    fail_run($sformatf("MISMATCH %s status: expected %b, actual %b", name, exp_v, act_v));
  end
endtask

task automatic check_tag(input string name, input fp_op_pkg::tag_t exp_v,
                         input fp_op_pkg::tag_t act_v);
  if (act_v !== exp_v) begin
    fail_run($sformatf("MISMATCH %s tag: expected %0d, actual %0d", name, exp_v, act_v));
  end
endtask

task automatic check_latency(input string name, input int exp_v, input int act_v);
  if (act_v != exp_v) begin
    fail_run($sformatf("MISMATCH %s latency: expected %0d, actual %0d", name, exp_v, act_v));
  end
endtask

`endif

//--- testbench/tb_noncomp_opgroup_block.sv
// --------------------------------------------------
// Testbench for the non-computational FP group
// Random stimulus with a scoreboard by tag, flush and latency checks
// --------------------------------------------------
`default_nettype none

module tb_noncomp_opgroup_block;

  localparam int Period = 100;
  localparam int Fp32Depth = 2;
  localparam int Fp16Depth = 1;
  localparam int NumPerTest = 80;
  localparam int NumTests = 5 * NumPerTest;
  localparam int WatchdogCycles = NumTests * 20;
  localparam logic [31:0] LfsrSeed = 32'haf33;

  logic             clk_i;
  logic             rst_i;
  fp_op_pkg::req_t  req_i;
  logic             in_valid_i;
  logic             in_ready_o;
  logic             flush_i;
  fp_op_pkg::resp_t resp_o;
  logic             out_valid_o;
  logic             out_ready_i;
  logic             busy_o;

  logic [31:0]      lfsr_state;

  // Scoreboard with one slot per tag
  fp_op_pkg::resp_t       sb_exp [16];
  bit                     sb_pending [16];
  fp_fmt_pkg::fp_format_e sb_fmt [16];
  longint                 sb_time [16];
  fp_op_pkg::tag_t        fp32_q [$];
  fp_op_pkg::tag_t        fp16_q [$];

  string            test_name;
  bit               latency_mode;
  bit               stall_prev;
  fp_op_pkg::resp_t held_resp;
  fp_op_pkg::tag_t  out_tag;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1, "stopped at first error");
  endtask

  `include "tb_ref_model.svh"

  noncomp_opgroup_block #(
    .Fp32PipeRegs ( Fp32Depth ),
    .Fp16PipeRegs ( Fp16Depth )
  ) UUT (
    .clk_i, .rst_i, .req_i, .in_valid_i, .in_ready_o, .flush_i,
    .resp_o, .out_valid_o, .out_ready_i, .busy_o
  );

  initial begin
    clk_i = 1'b0;
    forever #(Period / 2) clk_i = ~clk_i;
  end

  // --------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------
  function automatic logic [31:0] special_operand(input fp_fmt_pkg::fp_format_e fmt,
                                                  input logic [2:0] idx);
    logic [31:0] fp32_tab [8];
    logic [31:0] fp16_tab [8];
    fp32_tab = '{32'h0000_0000, 32'h8000_0000, 32'h7f80_0000, 32'hff80_0000,
                 32'h7fc0_0000, 32'h7f80_0001, 32'h3f80_0000, 32'hbf80_0000};
    // Last entry has a broken box
    fp16_tab = '{32'hffff_0000, 32'hffff_8000, 32'hffff_7c00, 32'hffff_fc00,
                 32'hffff_7e00, 32'hffff_7c01, 32'hffff_3c00, 32'h1234_3c00};
    return (fmt == fp_fmt_pkg::FP32) ? fp32_tab[idx] : fp16_tab[idx];
  endfunction

  function automatic logic [31:0] pick_operand(input fp_fmt_pkg::fp_format_e fmt);
    logic [31:0] raw;
    if (take_bits(1) != 0) begin
      return special_operand(fmt, take_bits(3));
    end
    raw = take_bits((fmt == fp_fmt_pkg::FP32) ? 32 : 16);
    return (fmt == fp_fmt_pkg::FP32) ? raw : {16'hffff, raw[15:0]};
  endfunction

  function automatic int pending_count();
    int n;
    n = 0;
    for (int t = 0; t < 16; t++) n += sb_pending[t];
    return n;
  endfunction

  task automatic record_accept(input fp_op_pkg::req_t req);
    sb_exp[req.tag] = ref_result(req);
    sb_pending[req.tag] = 1'b1;
    sb_fmt[req.tag] = req.dst_fmt;
    sb_time[req.tag] = $time;
    if (req.dst_fmt == fp_fmt_pkg::FP32) fp32_q.push_back(req.tag);
    else fp16_q.push_back(req.tag);
  endtask

  // op_class selects 0 min/max, 1 sign injection and compares, 2 any
  // fmt_mode selects 0 FP32, 1 FP16 or 2 random
  task automatic issue_items(input int count, input int op_class, input int fmt_mode,
                             input bit random_ready);
    fp_op_pkg::req_t req;
    logic [0:0]      fmt_bit;
    logic [2:0]      op_bits;
    logic [3:0]      tag_bits;
    bit              accepted;
    for (int i = 0; i < count; i++) begin
      fmt_bit = (fmt_mode == 2) ? take_bits(1) : fmt_mode;
      req.dst_fmt = fp_fmt_pkg::fp_format_e'(fmt_bit);
      if (op_class == 0) op_bits = take_bits(1);
      else if (op_class == 1) op_bits = 3'd2 + (take_bits(3) % 6);
      else op_bits = take_bits(3);
      req.op = fp_op_pkg::operation_e'(op_bits);
      tag_bits = take_bits(4);
      while (sb_pending[tag_bits]) tag_bits++;
      req.tag = tag_bits;
      req.operand_a = pick_operand(req.dst_fmt);
      req.operand_b = pick_operand(req.dst_fmt);
      req_i <= req;
      in_valid_i <= 1'b1;
      accepted = 1'b0;
      while (!accepted) begin
        @(posedge clk_i);
        if (random_ready) out_ready_i <= (take_bits(1) != 0);
        if (in_ready_o) begin
          accepted = 1'b1;
          record_accept(req);
        end
      end
    end
    in_valid_i <= 1'b0;
  endtask

  task automatic drain();
    out_ready_i <= 1'b1;
    while (pending_count() != 0 || busy_o) @(posedge clk_i);
    latency_mode = 1'b0;
  endtask

  task automatic flush_in_flight();
    test_name = "flush";
    out_ready_i <= 1'b0;
    issue_items(Fp32Depth, 2, 0, 1'b0);
    issue_items(Fp16Depth, 2, 1, 1'b0);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    // Flushed tags leave the scoreboard
    for (int t = 0; t < 16; t++) sb_pending[t] = 1'b0;
    fp32_q.delete();
    fp16_q.delete();
    @(posedge clk_i);
    if (out_valid_o || busy_o) fail_run("out_valid_o or busy_o still high after flush");
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    lfsr_state = LfsrSeed;
    rst_i = 1'b1;
    req_i = '0;
    in_valid_i = 1'b0;
    flush_i = 1'b0;
    out_ready_i = 1'b0;
    test_name = "reset";
    latency_mode = 1'b0;
    repeat (8) @(posedge clk_i);
    rst_i <= 1'b0;
    test_name = "minmax";
    issue_items(NumPerTest, 0, 2, 1'b1);
    drain();
    test_name = "sgnj_cmp";
    issue_items(NumPerTest, 1, 2, 1'b1);
    drain();
    test_name = "latency_fp32";
    latency_mode = 1'b1;
    issue_items(NumPerTest / 4, 2, 0, 1'b0);
    drain();
    test_name = "latency_fp16";
    latency_mode = 1'b1;
    issue_items(NumPerTest / 4, 2, 1, 1'b0);
    drain();
    test_name = "mixed";
    issue_items(NumPerTest, 2, 2, 1'b1);
    drain();
    flush_in_flight();
    test_name = "after_flush";
    issue_items(NumPerTest / 2, 2, 2, 1'b1);
    drain();
    $display("PASS: all tests");
    $finish;
  end

  // Output side scoreboard
  always @(posedge clk_i) begin
    if (!rst_i) begin
      if (in_ready_o && !in_valid_i) begin
        fail_run("in_ready_o was high while in_valid_i was low");
      end
      if (stall_prev) begin
        if (!out_valid_o) fail_run("out_valid_o dropped while the output was stalled");
        check_result({test_name, " stall"}, held_resp.result, resp_o.result);
        check_status({test_name, " stall"}, held_resp.status, resp_o.status);
        check_tag({test_name, " stall"}, held_resp.tag, resp_o.tag);
      end
      if (out_valid_o && out_ready_i) begin
        out_tag = resp_o.tag;
        if (!sb_pending[out_tag]) begin
          fail_run($sformatf("output tag %0d has no request waiting for it", out_tag));
        end
        check_result(test_name, sb_exp[out_tag].result, resp_o.result);
        check_status(test_name, sb_exp[out_tag].status, resp_o.status);
        if (sb_fmt[out_tag] == fp_fmt_pkg::FP32) begin
          check_tag({test_name, " fp32 order"}, fp32_q.pop_front(), out_tag);
        end else begin
          check_tag({test_name, " fp16 order"}, fp16_q.pop_front(), out_tag);
        end
        if (latency_mode) begin
          check_latency(test_name, (sb_fmt[out_tag] == fp_fmt_pkg::FP32) ? Fp32Depth : Fp16Depth,
                        int'(($time - sb_time[out_tag]) / Period));
        end
        sb_pending[out_tag] = 1'b0;
      end
      stall_prev = out_valid_o && !out_ready_i && !flush_i;
      held_resp = resp_o;
    end
  end

  initial begin
    stall_prev = 1'b0;
    #(WatchdogCycles * Period);
    fail_run($sformatf("timeout: run did not finish within %0d cycles", WatchdogCycles));
  end

endmodule

`default_nettype wire
